/* common/board_pkg.sv */
package board_pkg;

    // Joystick word, active high on the board side
    localparam int JOY_W = 10;

    // Bit positions inside a joystick word
    localparam int JOY_RIGHT = 0;
    localparam int JOY_LEFT  = 1;
    localparam int JOY_DOWN  = 2;
    localparam int JOY_UP    = 3;

    // Fire buttons
    localparam int JOY_B1 = 4;
    localparam int JOY_B2 = 5;
    localparam int JOY_B3 = 6;   // Dropped in three-button mode

    // Cabinet keys
    localparam int JOY_START = 7;
    localparam int JOY_COIN  = 8;
    localparam int JOY_PAUSE = 9;

    // Game reset hold counter width, caps the hold length at 255 clocks
    localparam int RST_CNT_W = 8;

endpackage

/* common/snd_pkg.sv */
package snd_pkg;

    // Width of one game sound sample
    localparam int SND_W = 16;

    // The same sample word seen two ways.
    // Cores deliver either two's complement or plain unsigned samples,
    // the sampler picks the view that matches the core.
    typedef union packed {
        logic signed [SND_W-1:0] s;   // Two's complement
        logic        [SND_W-1:0] u;   // Offset binary / unsigned
    } snd_word_u;

endpackage

/* filelist.f */
common/board_pkg.sv
common/snd_pkg.sv
logic/board_reset.sv
logic/joy_map.sv
sound/snd_sampler.sv
sound/snd_fifo.sv
sound/snd_pwm.sv
logic/jtframe_board.sv
sim/tb_board.sv

/* logic/board_reset.sv */
`timescale 1ns/1ps

module board_reset #(
    parameter int RST_CYCLES = 16
) (
    input  logic clk_rgb,
    input  logic rst,
    input  logic rst_req,
    input  logic downloading,
    input  logic dip_flip,
    output logic game_rst
);

    localparam int CW = board_pkg::RST_CNT_W;

    logic [CW-1:0] hold_cnt;
    logic [CW-1:0] hold_next;
    logic          dip_last;
    logic          flip_chg;
    logic          trigger;

    // Any edge on the flip switch restarts the game
    assign flip_chg = dip_flip != dip_last;
    assign trigger  = rst | rst_req | downloading | flip_chg;

    always_comb begin
        if (trigger) begin
            hold_next = CW'(RST_CYCLES);
        end else if (hold_cnt != '0) begin
            hold_next = hold_cnt - 1'b1;
        end else begin
            hold_next = '0;
        end
    end

    always_ff @(posedge clk_rgb) begin
        dip_last <= dip_flip;   // Sampled every cycle, also during rst
        hold_cnt <= hold_next;
        game_rst <= hold_next != '0;   // High for RST_CYCLES after last trigger
    end

    // A system reset must always reach the game one clock later
    a_rst_to_game: assert property (
        @(posedge clk_rgb) rst |=> game_rst
    ) else $error("game_rst missing after rst");

endmodule

/* logic/joy_map.sv */
`timescale 1ns/1ps

module joy_map #(
    parameter bit THREE_BUTTONS           = 1'b0,
    parameter bit GAME_INPUTS_ACTIVE_HIGH = 1'b0
) (
    input  logic                       clk_rgb,
    input  logic                       game_rst,
    input  logic [board_pkg::JOY_W-1:0] board_joystick1,
    input  logic [board_pkg::JOY_W-1:0] board_joystick2,
    output logic [board_pkg::JOY_W-1:0] game_joystick1,
    output logic [board_pkg::JOY_W-1:0] game_joystick2,
    output logic [1:0]                 game_coin,
    output logic [1:0]                 game_start,
    output logic                       game_pause,
    output logic                       game_service
);

    localparam int JW = board_pkg::JOY_W;
    localparam bit INV = !GAME_INPUTS_ACTIVE_HIGH;

    logic [1:0] pause_now;
    logic [1:0] pause_last;
    logic       pause_rise;
    logic [1:0] coin_hi;
    logic [1:0] start_hi;
    logic       service_hi;

    // Directions and fire buttons only, cabinet keys go out separately
    function automatic logic [JW-1:0] map_joy(input logic [JW-1:0] b);
        logic [JW-1:0] g;
        g = '0;
        g[board_pkg::JOY_B3:board_pkg::JOY_RIGHT] = b[board_pkg::JOY_B3:board_pkg::JOY_RIGHT];
        if (THREE_BUTTONS) begin
            g[board_pkg::JOY_B3] = 1'b0;
        end
        return g;
    endfunction

    assign coin_hi    = {board_joystick2[board_pkg::JOY_COIN], board_joystick1[board_pkg::JOY_COIN]};
    assign start_hi   = {board_joystick2[board_pkg::JOY_START], board_joystick1[board_pkg::JOY_START]};
    assign service_hi = |(coin_hi & start_hi);   // Coin+start on the same stick

    assign pause_now  = {board_joystick2[board_pkg::JOY_PAUSE], board_joystick1[board_pkg::JOY_PAUSE]};
    assign pause_rise = |(pause_now & ~pause_last);

    always_ff @(posedge clk_rgb) begin
        game_joystick1 <= map_joy(board_joystick1) ^ {JW{INV}};
        game_joystick2 <= map_joy(board_joystick2) ^ {JW{INV}};
        game_coin      <= coin_hi ^ {2{INV}};
        game_start     <= start_hi ^ {2{INV}};
        game_service   <= service_hi ^ INV;
    end

    // Pause is a level for the core, flipped by each new press
    always_ff @(posedge clk_rgb) begin
        pause_last <= pause_now;
        if (game_rst) begin
            game_pause <= 1'b0;
        end else if (pause_rise) begin
            game_pause <= ~game_pause;
        end
    end

endmodule

/* logic/jtframe_board.sv */
`timescale 1ns/1ps

module jtframe_board #(
    parameter bit SIGNED_SND              = 1'b0,
    parameter bit THREE_BUTTONS           = 1'b0,
    parameter bit GAME_INPUTS_ACTIVE_HIGH = 1'b0,
    parameter int RST_CYCLES              = 16,
    parameter int FIFO_DEPTH              = 8,   // Power of two
    parameter int SAMPLE_DIV              = 8    // Clocks per output sample, 4 or more
) (
    input  logic                       clk_rgb,
    input  logic                       rst,
    input  logic                       rst_req,
    input  logic                       downloading,
    input  logic                       dip_flip,
    input  logic [board_pkg::JOY_W-1:0] board_joystick1,
    input  logic [board_pkg::JOY_W-1:0] board_joystick2,
    input  logic [snd_pkg::SND_W-1:0]   snd,
    input  logic                       snd_cen,
    output logic                       game_rst,
    output logic [board_pkg::JOY_W-1:0] game_joystick1,
    output logic [board_pkg::JOY_W-1:0] game_joystick2,
    output logic [1:0]                 game_coin,
    output logic [1:0]                 game_start,
    output logic                       game_pause,
    output logic                       game_service,
    output logic                       AUDIO_L,
    output logic                       AUDIO_R,
    output logic                       snd_overrun
);

    // Sample path between sampler, FIFO and modulator
    logic                      fifo_wr;
    logic [snd_pkg::SND_W-1:0] fifo_d;
    logic                      fifo_rd;
    logic [snd_pkg::SND_W-1:0] fifo_q;
    logic                      fifo_empty;
    logic                      fifo_full;

    assign AUDIO_R = AUDIO_L;   // Mono

    board_reset #(.RST_CYCLES(RST_CYCLES)) u_reset (
        .clk_rgb        ( clk_rgb         ),
        .rst            ( rst             ),
        .rst_req        ( rst_req         ),
        .downloading    ( downloading     ),
        .dip_flip       ( dip_flip        ),
        .game_rst       ( game_rst        )
    );

    joy_map #(
        .THREE_BUTTONS          ( THREE_BUTTONS           ),
        .GAME_INPUTS_ACTIVE_HIGH( GAME_INPUTS_ACTIVE_HIGH )
    ) u_joy (
        .clk_rgb        ( clk_rgb         ),
        .game_rst       ( game_rst        ),
        .board_joystick1( board_joystick1 ),
        .board_joystick2( board_joystick2 ),
        .game_joystick1 ( game_joystick1  ),
        .game_joystick2 ( game_joystick2  ),
        .game_coin      ( game_coin       ),
        .game_start     ( game_start      ),
        .game_pause     ( game_pause      ),
        .game_service   ( game_service    )
    );

    snd_sampler #(.SIGNED_SND(SIGNED_SND)) u_sampler (
        .clk_rgb        ( clk_rgb         ),
        .game_rst       ( game_rst        ),
        .snd            ( snd             ),
        .snd_cen        ( snd_cen         ),
        .fifo_full      ( fifo_full       ),
        .fifo_wr        ( fifo_wr         ),
        .fifo_d         ( fifo_d          ),
        .snd_overrun    ( snd_overrun     )
    );

    snd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk_rgb        ( clk_rgb         ),
        .game_rst       ( game_rst        ),
        .fifo_wr        ( fifo_wr         ),
        .fifo_d         ( fifo_d          ),
        .fifo_rd        ( fifo_rd         ),
        .fifo_q         ( fifo_q          ),
        .fifo_empty     ( fifo_empty      ),
        .fifo_full      ( fifo_full       )
    );

    snd_pwm #(.SAMPLE_DIV(SAMPLE_DIV)) u_pwm (
        .clk_rgb        ( clk_rgb         ),
        .game_rst       ( game_rst        ),
        .fifo_empty     ( fifo_empty      ),
        .fifo_q         ( fifo_q          ),
        .fifo_rd        ( fifo_rd         ),
        .snd_pwm        ( AUDIO_L         )
    );

endmodule

/* sim/tb_board.sv */
`timescale 1ns/1ps

module tb_board;

    localparam int JW          = board_pkg::JOY_W;
    localparam int SW          = snd_pkg::SND_W;
    localparam int RST_CYCLES  = 16;
    localparam int SAMPLE_DIV  = 8;
    localparam int RESET_LEN   = 3000;
    localparam int JOY_LEN     = 500;
    localparam int PAUSE_LEN   = 1000;
    localparam int SETTLE_LEN  = 64;
    localparam int DENSITY_LEN = 1024;
    localparam int TEST_CYCLES = 8 + RESET_LEN + JOY_LEN + PAUSE_LEN
                                 + 5 * (SETTLE_LEN + DENSITY_LEN) + 200;
    localparam int CYCLE_LIMIT = TEST_CYCLES * 11 / 10;

    logic          clk_rgb = 1'b0;
    logic          rst;
    logic          rst_req;
    logic          downloading;
    logic          dip_flip;
    logic [JW-1:0] board_joystick1;
    logic [JW-1:0] board_joystick2;
    logic [SW-1:0] snd;
    logic          snd_cen;
    logic          game_rst;
    logic [JW-1:0] game_joystick1;
    logic [JW-1:0] game_joystick2;
    logic [1:0]    game_coin;
    logic [1:0]    game_start;
    logic          game_pause;
    logic          game_service;
    logic          AUDIO_L;
    logic          AUDIO_R;
    logic          snd_overrun;

    // Reference model state, updated once per clock
    int            m_cnt        = RST_CYCLES;
    logic          m_grst       = 1'b1;
    logic          m_dip_last   = 1'b0;
    logic          m_pause      = 1'b0;
    logic [1:0]    m_pause_last = 2'b00;
    logic [JW-1:0] m_joy1;
    logic [JW-1:0] m_joy2;
    logic [1:0]    m_coin;
    logic [1:0]    m_start;
    logic          m_service;

    logic [31:0]   lfsr_state = 32'he469_e768;
    int            cycles     = 0;
    logic          checking   = 1'b0;   // Off until the DUT leaves reset

    jtframe_board #(
        .SIGNED_SND             ( 1'b1       ),
        .THREE_BUTTONS          ( 1'b1       ),
        .GAME_INPUTS_ACTIVE_HIGH( 1'b0       ),
        .RST_CYCLES             ( RST_CYCLES ),
        .FIFO_DEPTH             ( 8          ),
        .SAMPLE_DIV             ( SAMPLE_DIV )
    ) DUT (
        .clk_rgb        ( clk_rgb         ),
        .rst            ( rst             ),
        .rst_req        ( rst_req         ),
        .downloading    ( downloading     ),
        .dip_flip       ( dip_flip        ),
        .board_joystick1( board_joystick1 ),
        .board_joystick2( board_joystick2 ),
        .snd            ( snd             ),
        .snd_cen        ( snd_cen         ),
        .game_rst       ( game_rst        ),
        .game_joystick1 ( game_joystick1  ),
        .game_joystick2 ( game_joystick2  ),
        .game_coin      ( game_coin       ),
        .game_start     ( game_start      ),
        .game_pause     ( game_pause      ),
        .game_service   ( game_service    ),
        .AUDIO_L        ( AUDIO_L         ),
        .AUDIO_R        ( AUDIO_R         ),
        .snd_overrun    ( snd_overrun     )
    );

    always #20 clk_rgb = ~clk_rgb;

    always @(posedge clk_rgb) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: test still running after %0d cycles", cycles);
            $display("** FAIL **");
            $fatal(1, "cycle limit reached");
        end
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] v);
        return v[0] ? ((v >> 1) ^ 32'h8020_0003) : (v >> 1);
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // Game word seen by the core, active low, only directions plus B1 and B2
    function automatic logic [JW-1:0] expect_joy(input logic [JW-1:0] b);
        logic [JW-1:0] g;
        g = '0;
        g[board_pkg::JOY_RIGHT] = b[board_pkg::JOY_RIGHT];
        g[board_pkg::JOY_LEFT]  = b[board_pkg::JOY_LEFT];
        g[board_pkg::JOY_DOWN]  = b[board_pkg::JOY_DOWN];
        g[board_pkg::JOY_UP]    = b[board_pkg::JOY_UP];
        g[board_pkg::JOY_B1]    = b[board_pkg::JOY_B1];
        g[board_pkg::JOY_B2]    = b[board_pkg::JOY_B2];
        return ~g;
    endfunction

    task automatic model_update();
        logic       trigger;
        logic [1:0] pause_now;
        logic [1:0] coin;
        logic [1:0] start;
        trigger   = rst | rst_req | downloading | (dip_flip != m_dip_last);
        pause_now = {board_joystick2[board_pkg::JOY_PAUSE], board_joystick1[board_pkg::JOY_PAUSE]};
        coin      = {board_joystick2[board_pkg::JOY_COIN], board_joystick1[board_pkg::JOY_COIN]};
        start     = {board_joystick2[board_pkg::JOY_START], board_joystick1[board_pkg::JOY_START]};
        if (m_grst) begin
            m_pause = 1'b0;
        end else if (|(pause_now & ~m_pause_last)) begin
            m_pause = ~m_pause;
        end
        m_pause_last = pause_now;
        if (trigger) begin
            m_cnt = RST_CYCLES;
        end else if (m_cnt != 0) begin
            m_cnt = m_cnt - 1;
        end
        m_grst     = m_cnt != 0;
        m_dip_last = dip_flip;
        m_joy1     = expect_joy(board_joystick1);
        m_joy2     = expect_joy(board_joystick2);
        m_coin     = ~coin;
        m_start    = ~start;
        m_service  = ~|(coin & start);
    endtask

    task automatic check_outputs();
        compare("game_rst", game_rst, m_grst);
        compare("game_joystick1", game_joystick1, m_joy1);
        compare("game_joystick2", game_joystick2, m_joy2);
        compare("game_coin", game_coin, m_coin);
        compare("game_start", game_start, m_start);
        compare("game_service", game_service, m_service);
        compare("game_pause", game_pause, m_pause);
        compare("AUDIO_R", AUDIO_R, AUDIO_L);
    endtask

    // Inputs are set before the call, outputs checked at the next falling edge
    task automatic next_cycle();
        model_update();
        @(negedge clk_rgb);
        if (checking) begin
            check_outputs();
        end
    endtask

    initial begin
        int            count;
        int            expected;
        logic [SW-1:0] level;
        logic [SW-1:0] samples [5];
        rst             = 1'b1;
        rst_req         = 1'b0;
        downloading     = 1'b0;
        dip_flip        = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        snd             = '0;
        snd_cen         = 1'b0;
        repeat (8) next_cycle();
        rst      = 1'b0;
        checking = 1'b1;

        // Reset triggers, sparse enough that game_rst also falls
        for (int i = 0; i < RESET_LEN; i++) begin
            rst_req     = random_bits(6) == 0;
            downloading = random_bits(6) == 0;
            if (random_bits(7) == 0) begin
                dip_flip = ~dip_flip;
            end
            next_cycle();
        end
        rst_req     = 1'b0;
        downloading = 1'b0;

        for (int i = 0; i < JOY_LEN; i++) begin
            board_joystick1 = JW'(random_bits(JW));
            board_joystick2 = JW'(random_bits(JW));
            next_cycle();
        end
        board_joystick1 = '0;
        board_joystick2 = '0;

        // Pause presses with the odd flip-switch reset
        for (int i = 0; i < PAUSE_LEN; i++) begin
            if (random_bits(3) == 0) begin
                board_joystick1[board_pkg::JOY_PAUSE] = ~board_joystick1[board_pkg::JOY_PAUSE];
            end
            if (random_bits(3) == 0) begin
                board_joystick2[board_pkg::JOY_PAUSE] = ~board_joystick2[board_pkg::JOY_PAUSE];
            end
            if (i == PAUSE_LEN / 2 || random_bits(8) == 0) begin
                dip_flip = ~dip_flip;
            end
            next_cycle();
        end

        // Directed pause set, then clear through dip_flip
        board_joystick1 = '0;
        board_joystick2 = '0;
        dip_flip        = ~dip_flip;
        repeat (20) next_cycle();
        board_joystick2[board_pkg::JOY_PAUSE] = 1'b1;
        repeat (2) next_cycle();
        compare("game_pause after press", game_pause, 1);
        dip_flip = ~dip_flip;
        repeat (3) next_cycle();
        compare("game_pause after flip reset", game_pause, 0);
        board_joystick2 = '0;

        samples[0] = 16'h0000;
        samples[1] = {1'b0, 15'(random_bits(15))};
        samples[2] = {1'b1, 15'(random_bits(15))};
        samples[3] = 16'h7fff;
        samples[4] = 16'h8000;
        foreach (samples[j]) begin
            snd      = samples[j];
            level    = samples[j] ^ 16'h8000;   // Offset binary
            expected = (int'(level) * DENSITY_LEN) / 65536;
            count    = 0;
            for (int i = 0; i < SETTLE_LEN + DENSITY_LEN; i++) begin
                snd_cen = (i % SAMPLE_DIV) == 0;
                next_cycle();
                if (i >= SETTLE_LEN && AUDIO_L) begin
                    count++;
                end
            end
            $display("Sample %h: %0d high cycles, expected %0d", samples[j], count, expected);
            compare("AUDIO_L density in range",
                    (count >= expected - 1) && (count <= expected + 1), 1);
        end
        snd_cen = 1'b0;
        compare("snd_overrun after paced samples", snd_overrun, 0);

        // Burst into a fresh FIFO
        rst_req = 1'b1;
        next_cycle();
        rst_req = 1'b0;
        while (game_rst) begin
            next_cycle();
        end
        for (int i = 0; i < 16; i++) begin
            snd_cen = 1'b1;
            snd     = SW'(random_bits(SW));
            next_cycle();
        end
        snd_cen = 1'b0;
        repeat (2) next_cycle();
        compare("snd_overrun after burst", snd_overrun, 1);
        rst_req = 1'b1;
        next_cycle();
        rst_req = 1'b0;
        repeat (2) next_cycle();
        compare("snd_overrun after game_rst", snd_overrun, 0);

        $display("** PASS **");
        $finish;
    end

endmodule

/* sound/snd_fifo.sv */
`timescale 1ns/1ps

module snd_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                     clk_rgb,
    input  logic                     game_rst,
    input  logic                     fifo_wr,
    input  logic [snd_pkg::SND_W-1:0] fifo_d,
    input  logic                     fifo_rd,
    output logic [snd_pkg::SND_W-1:0] fifo_q,
    output logic                     fifo_empty,
    output logic                     fifo_full
);

    localparam int SW = snd_pkg::SND_W;
    localparam int AW = $clog2(FIFO_DEPTH);

    logic [SW-1:0] mem [FIFO_DEPTH];
    logic [AW:0]   wr_ptr;   // Extra bit tells full from empty
    logic [AW:0]   rd_ptr;
    logic          do_wr;
    logic          do_rd;

    assign fifo_empty = wr_ptr == rd_ptr;
    assign fifo_full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                        (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Guarded so a stray strobe cannot corrupt the pointers
    assign do_wr = fifo_wr & ~fifo_full;
    assign do_rd = fifo_rd & ~fifo_empty;

    always_ff @(posedge clk_rgb) begin
        if (game_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage and output word
    always_ff @(posedge clk_rgb) begin
        if (do_wr) begin
            mem[wr_ptr[AW-1:0]] <= fifo_d;
        end
        if (do_rd) begin
            fifo_q <= mem[rd_ptr[AW-1:0]];   // Oldest word, valid next cycle
        end
    end

    // The sampler must hold off on full
    a_no_wr_full: assert property (
        @(posedge clk_rgb) disable iff (game_rst) !(fifo_wr && fifo_full)
    ) else $error("sample FIFO written while full");

    // The modulator must only read when data is there
    a_no_rd_empty: assert property (
        @(posedge clk_rgb) disable iff (game_rst) !(fifo_rd && fifo_empty)
    ) else $error("sample FIFO read while empty");

endmodule

/* sound/snd_pwm.sv */
`timescale 1ns/1ps

module snd_pwm #(
    parameter int SAMPLE_DIV = 8
) (
    input  logic                     clk_rgb,
    input  logic                     game_rst,
    input  logic                     fifo_empty,
    input  logic [snd_pkg::SND_W-1:0] fifo_q,
    output logic                     fifo_rd,
    output logic                     snd_pwm
);

    localparam int SW = snd_pkg::SND_W;
    localparam int DW = $clog2(SAMPLE_DIV);

    logic [DW-1:0] div_cnt;
    logic          last_cyc;
    logic          rd_dly;     // fifo_q is valid while this is high
    logic [SW-1:0] sample;
    logic [SW-1:0] acc_lo;
    logic [SW:0]   acc;        // Low part plus sample, MSB is the carry

    // Sample rate divider
    assign last_cyc = div_cnt == DW'(SAMPLE_DIV - 1);
    assign fifo_rd  = last_cyc & ~fifo_empty;

    always_ff @(posedge clk_rgb) begin
        if (game_rst) begin
            div_cnt <= '0;
            rd_dly  <= 1'b0;
        end else begin
            div_cnt <= last_cyc ? '0 : div_cnt + 1'b1;
            rd_dly  <= fifo_rd;
        end
    end

    // An empty FIFO leaves the old sample playing
    always_ff @(posedge clk_rgb) begin
        if (game_rst) begin
            sample <= '0;
        end else if (rd_dly) begin
            sample <= fifo_q;
        end
    end

    // First order delta-sigma
    assign acc = {1'b0, acc_lo} + {1'b0, sample};

    always_ff @(posedge clk_rgb) begin
        if (game_rst) begin
            acc_lo  <= '0;
            snd_pwm <= 1'b0;
        end else begin
            acc_lo  <= acc[SW-1:0];
            snd_pwm <= acc[SW];   // Carry density follows sample/2^SW
        end
    end

    // One read per sample period at most
    a_rd_single: assert property (
        @(posedge clk_rgb) disable iff (game_rst) fifo_rd |=> !fifo_rd
    ) else $error("fifo_rd high on consecutive cycles");

endmodule

/* sound/snd_sampler.sv */
`timescale 1ns/1ps

module snd_sampler #(
    parameter bit SIGNED_SND = 1'b1
) (
    input  logic                     clk_rgb,
    input  logic                     game_rst,
    input  logic [snd_pkg::SND_W-1:0] snd,
    input  logic                     snd_cen,
    input  logic                     fifo_full,
    output logic                     fifo_wr,
    output logic [snd_pkg::SND_W-1:0] fifo_d,
    output logic                     snd_overrun
);

    localparam int SW = snd_pkg::SND_W;

    snd_pkg::snd_word_u word;
    logic [SW-1:0]      offset;
    logic               pend;   // Sample captured, write due this cycle

    assign word = snd;

    // Everything downstream works on offset binary
    always_comb begin
        if (SIGNED_SND) begin
            offset = SW'(int'(word.s) + (1 << (SW-1)));
        end else begin
            offset = word.u;
        end
    end

    always_ff @(posedge clk_rgb) begin
        if (snd_cen) begin
            fifo_d <= offset;
        end
    end

    // Full is checked when the write actually happens
    assign fifo_wr = pend & ~fifo_full;

    always_ff @(posedge clk_rgb) begin
        if (game_rst) begin
            pend        <= 1'b0;
            snd_overrun <= 1'b0;
        end else begin
            pend <= snd_cen;
            if (pend && fifo_full) begin
                snd_overrun <= 1'b1;   // Sample lost, sticky
            end
        end
    end

endmodule
